//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_retire, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_retire \
		-f flist.f -Mdir obj_dir -o sim_retire
	./obj_dir/sim_retire | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/retire_assertions.sv
`include "lc3b_defines.svh"

module retire_assertions
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic pc_sel,
	input logic dmem_write,
	input logic disp_valid,
	input logic disp_ready,
	input logic retire
);

	localparam logic [`LC3B_TAG_W:0] full_count = (`LC3B_TAG_W + 1)'(`LC3B_ROB_DEPTH);

	logic [`LC3B_TAG_W:0] outstanding; // entries held in the ROB.
	logic alloc;

	assign alloc = disp_valid & disp_ready;

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			outstanding <= '0;
		else if (alloc && !retire)
			outstanding <= outstanding + 1'b1;
		else if (retire && !alloc)
			outstanding <= outstanding - 1'b1;
	end

	flush_with_pc_sel: assert property (@(posedge clk) flush |-> pc_sel)
		else $error("flush raised without pc_sel");

	no_write_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !dmem_write)
		else $error("dmem_write high during reset");

	full_stalls_dispatch: assert property (@(posedge clk) disable iff (rst)
		outstanding == full_count |-> !disp_ready)
		else $error("disp_ready high with every ROB entry in use");

endmodule

bind lc3b_retire_top retire_assertions retire_assertions0
(
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.pc_sel(pc_sel),
	.dmem_write(dmem_write),
	.disp_valid(disp_valid),
	.disp_ready(disp_ready),
	.retire(retire)
);

//--- dv/tb_retire.sv
`include "lc3b_defines.svh"

module tb_retire;

	localparam int max_cycles = 2000; // tests take a few hundred cycles.

	logic clk;
	logic rst;
	logic disp_valid;
	lc3b_types_pkg::lc3b_opcode disp_opcode;
	lc3b_types_pkg::lc3b_reg disp_dest;
	lc3b_types_pkg::lc3b_word disp_link;
	logic disp_ready;
	lc3b_types_pkg::lc3b_rob_tag disp_tag;
	logic res_valid;
	lc3b_types_pkg::lc3b_rob_tag res_tag;
	lc3b_types_pkg::lc3b_word res_value;
	logic res_predict;
	logic dmem_resp;
	lc3b_types_pkg::lc3b_reg rd_sel;
	lc3b_types_pkg::lc3b_word rd_value;
	logic rd_busy;
	logic dmem_write;
	logic flush;
	logic pc_sel;
	lc3b_types_pkg::lc3b_word new_pc;
	logic [31:0] branch_count;
	logic [31:0] mispredict_count;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int seed = 32'h085b063c;
	logic [31:0] exp_branches = '0;
	logic [31:0] exp_mispredicts = '0;

	lc3b_retire_top dut0
	(
		.clk, .rst,
		.disp_valid, .disp_opcode, .disp_dest, .disp_link, .disp_ready, .disp_tag,
		.res_valid, .res_tag, .res_value, .res_predict,
		.dmem_resp, .rd_sel, .rd_value, .rd_busy,
		.dmem_write, .flush, .pc_sel, .new_pc,
		.branch_count, .mispredict_count
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("timeout: tests still running after %0d cycles", max_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at time %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic dispatch(input lc3b_types_pkg::lc3b_opcode op,
		input lc3b_types_pkg::lc3b_reg dest, input lc3b_types_pkg::lc3b_word link,
		output lc3b_types_pkg::lc3b_rob_tag tag);
		@(posedge clk);
		disp_valid <= 1'b1;
		disp_opcode <= op;
		disp_dest <= dest;
		disp_link <= link;
		@(negedge clk);
		while (!disp_ready)
			@(negedge clk);
		tag = disp_tag; // tail, stable until the allocating edge.
		@(posedge clk);
		disp_valid <= 1'b0;
	endtask

	task automatic send_result(input lc3b_types_pkg::lc3b_rob_tag tag,
		input lc3b_types_pkg::lc3b_word value, input logic predict);
		@(posedge clk);
		res_valid <= 1'b1;
		res_tag <= tag;
		res_value <= value;
		res_predict <= predict;
		@(posedge clk);
		res_valid <= 1'b0;
	endtask

	task automatic select_reg(input lc3b_types_pkg::lc3b_reg r);
		@(posedge clk);
		rd_sel <= r;
		@(negedge clk);
	endtask

	task automatic expect_reg(input lc3b_types_pkg::lc3b_reg r,
		input lc3b_types_pkg::lc3b_word value, input logic busy, input string what);
		select_reg(r);
		compare(32'(rd_value), 32'(value), {what, " value"});
		compare(32'(rd_busy), 32'(busy), {what, " busy"});
	endtask

	task automatic in_order_retire();
		lc3b_types_pkg::lc3b_rob_tag t1;
		lc3b_types_pkg::lc3b_rob_tag t2;
		lc3b_types_pkg::lc3b_word v1;
		lc3b_types_pkg::lc3b_word v2;
		v1 = 16'($random(seed));
		v2 = 16'($random(seed));
		dispatch(lc3b_types_pkg::op_add, 3'd1, 16'h0000, t1);
		dispatch(lc3b_types_pkg::op_add, 3'd2, 16'h0000, t2);
		send_result(t2, v2, 1'b0); // younger result first.
		select_reg(3'd1);
		compare(32'(rd_busy), 32'd1, "R1 busy before its result");
		select_reg(3'd2);
		compare(32'(rd_busy), 32'd1, "R2 busy behind R1");
		send_result(t1, v1, 1'b0);
		expect_reg(3'd1, v1, 1'b0, "in order R1");
		expect_reg(3'd2, v2, 1'b0, "in order R2");
	endtask

	task automatic busy_ownership();
		lc3b_types_pkg::lc3b_rob_tag ta;
		lc3b_types_pkg::lc3b_rob_tag tb;
		dispatch(lc3b_types_pkg::op_add, 3'd3, 16'h0000, ta);
		dispatch(lc3b_types_pkg::op_and, 3'd3, 16'h0000, tb);
		send_result(ta, 16'h0033, 1'b0);
		expect_reg(3'd3, 16'h0033, 1'b1, "R3 after older write"); // second write owns R3.
		send_result(tb, 16'h0333, 1'b0);
		expect_reg(3'd3, 16'h0333, 1'b0, "R3 after younger write");
	endtask

	task automatic run_branch(input lc3b_types_pkg::lc3b_nzp mask,
		input lc3b_types_pkg::lc3b_word target, input logic predict, input logic exp_mis);
		lc3b_types_pkg::lc3b_rob_tag t;
		dispatch(lc3b_types_pkg::op_br, mask, 16'h0000, t); // mask in dest.
		send_result(t, target, predict);
		@(negedge clk);
		compare(32'(flush), 32'(exp_mis), "branch flush");
		compare(32'(pc_sel), 32'(exp_mis), "branch pc_sel");
		if (exp_mis)
			compare(32'(new_pc), 32'(target), "branch new_pc");
		exp_branches = exp_branches + 1;
		if (exp_mis)
			exp_mispredicts = exp_mispredicts + 1;
		@(posedge clk);
		@(negedge clk);
		compare(branch_count, exp_branches, "branch_count");
		compare(mispredict_count, exp_mispredicts, "mispredict_count");
	endtask

	task automatic branch_resolution();
		lc3b_types_pkg::lc3b_rob_tag t;
		dispatch(lc3b_types_pkg::op_add, 3'd5, 16'h0000, t);
		send_result(t, 16'h8001, 1'b0); // negative, codes become n.
		run_branch(3'b100, 16'h3000, 1'b0, 1'b1); // taken, predicted not taken.
		run_branch(3'b100, 16'h3100, 1'b1, 1'b0);
	endtask

	task automatic store_backpressure();
		lc3b_types_pkg::lc3b_rob_tag ts;
		lc3b_types_pkg::lc3b_rob_tag ta;
		dispatch(lc3b_types_pkg::op_add, 3'd6, 16'h0000, ta);
		send_result(ta, 16'h0006, 1'b0);
		dispatch(lc3b_types_pkg::op_str, 3'd0, 16'h0000, ts);
		dispatch(lc3b_types_pkg::op_add, 3'd6, 16'h0000, ta);
		send_result(ts, 16'h0200, 1'b0);
		send_result(ta, 16'h0066, 1'b0);
		repeat (4)
		begin
			select_reg(3'd6);
			compare(32'(dmem_write), 32'd1, "dmem_write while store waits");
			compare(32'(rd_value), 32'h0006, "R6 held behind store");
			compare(32'(rd_busy), 32'd1, "R6 busy behind store");
		end
		@(posedge clk);
		dmem_resp <= 1'b1;
		@(posedge clk);
		dmem_resp <= 1'b0; // store pops on this edge.
		expect_reg(3'd6, 16'h0066, 1'b0, "R6 after store");
		compare(32'(dmem_write), 32'd0, "dmem_write after store");
	endtask

	task automatic trap_and_flush();
		lc3b_types_pkg::lc3b_rob_tag tt;
		lc3b_types_pkg::lc3b_rob_tag ta;
		dispatch(lc3b_types_pkg::op_add, 3'd4, 16'h0000, ta);
		send_result(ta, 16'h0044, 1'b0);
		dispatch(lc3b_types_pkg::op_trap, 3'd7, 16'h1234, tt);
		dispatch(lc3b_types_pkg::op_add, 3'd4, 16'h0000, ta);
		send_result(ta, 16'h4444, 1'b0);
		send_result(tt, 16'h0400, 1'b0);
		@(negedge clk);
		compare(32'(flush), 32'd1, "trap flush");
		compare(32'(pc_sel), 32'd1, "trap pc_sel");
		compare(32'(new_pc), 32'h0400, "trap new_pc");
		expect_reg(3'd7, 16'h1234, 1'b0, "R7 link");
		expect_reg(3'd4, 16'h0044, 1'b0, "R4 after flush");
	endtask

	task automatic full_rob();
		lc3b_types_pkg::lc3b_rob_tag t;
		lc3b_types_pkg::lc3b_rob_tag first;
		for (int i = 0; i < `LC3B_ROB_DEPTH; i++)
		begin
			dispatch(lc3b_types_pkg::op_add, 3'd0, 16'h0000, t);
			compare(32'(t), 32'(i), "disp_tag from an emptied ROB"); // flush reset the tail.
			if (i == 0)
				first = t;
		end
		@(negedge clk);
		compare(32'(disp_ready), 32'd0, "disp_ready with ROB full");
		send_result(first, 16'h0077, 1'b0);
		@(posedge clk);
		@(negedge clk);
		compare(32'(disp_ready), 32'd1, "disp_ready after one retire");
	endtask

	initial
	begin
		rst <= 1'b1;
		disp_valid <= 1'b0;
		disp_opcode <= lc3b_types_pkg::op_add;
		disp_dest <= '0;
		disp_link <= '0;
		res_valid <= 1'b0;
		res_tag <= '0;
		res_value <= '0;
		res_predict <= 1'b0;
		dmem_resp <= 1'b0;
		rd_sel <= '0;
		repeat (8)
			@(posedge clk);
		rst <= 1'b0;
		in_order_retire();
		busy_ownership();
		branch_resolution();
		store_backpressure();
		trap_and_flush();
		full_rob();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- flist.f
+incdir+src
src/lc3b_types_pkg.sv
src/lc3b_rob.sv
src/lc3b_commit_control.sv
src/lc3b_regfile.sv
src/lc3b_retire_top.sv
dv/retire_assertions.sv
dv/tb_retire.sv

//--- src/lc3b_commit_control.sv
`include "lc3b_defines.svh"

module lc3b_commit_control
(
	input logic clk,
	input logic rst,

	input logic head_valid,
	input lc3b_types_pkg::lc3b_opcode head_opcode,
	input lc3b_types_pkg::lc3b_reg head_dest,
	input lc3b_types_pkg::lc3b_word head_value,
	input logic head_predict,
	input lc3b_types_pkg::lc3b_word head_link,
	input lc3b_types_pkg::lc3b_rob_tag head_tag,

	input lc3b_types_pkg::lc3b_rob_tag owner_tag,
	input logic dmem_resp,

	output logic retire,
	output logic wr_en,
	output lc3b_types_pkg::lc3b_reg wr_dest,
	output lc3b_types_pkg::lc3b_word wr_value,
	output logic wr_clear_busy,
	output logic dmem_write,
	output logic flush,
	output logic pc_sel,
	output lc3b_types_pkg::lc3b_word new_pc,

	output logic [31:0] branch_count,
	output logic [31:0] mispredict_count
);

	lc3b_types_pkg::lc3b_nzp cc; // current condition codes.
	lc3b_types_pkg::lc3b_nzp gen_cc;
	logic ld_cc;
	logic value_neg;
	logic value_zero;
	logic taken;
	logic mispredict;
	logic is_trap;

	assign value_neg = head_value[`LC3B_WORD_W-1];
	assign value_zero = (head_value == '0);
	assign gen_cc = {value_neg, value_zero, ~value_neg & ~value_zero};

	// branch mask sits in the dest field.
	assign taken = |(head_dest & cc);
	assign mispredict = (taken != head_predict);

	assign is_trap = (head_opcode == lc3b_types_pkg::op_trap);
	assign wr_dest = is_trap ? lc3b_types_pkg::lc3b_reg'(7) : head_dest; // trap links to R7.
	assign wr_value = is_trap ? head_link : head_value;
	assign new_pc = head_value; // branch target or trap vector.

	always_comb
	begin
		retire = 1'b0;
		wr_en = 1'b0;
		wr_clear_busy = 1'b0;
		ld_cc = 1'b0;
		dmem_write = 1'b0;
		flush = 1'b0;
		pc_sel = 1'b0;
		if (head_valid)
		begin
			case (head_opcode)
				lc3b_types_pkg::op_add,
				lc3b_types_pkg::op_and,
				lc3b_types_pkg::op_not,
				lc3b_types_pkg::op_lea,
				lc3b_types_pkg::op_ldr:
				begin
					retire = 1'b1;
					wr_en = 1'b1;
					wr_clear_busy = (owner_tag == head_tag);
					ld_cc = 1'b1;
				end
				lc3b_types_pkg::op_jsr:
				begin
					retire = 1'b1;
					wr_en = 1'b1;
					wr_clear_busy = (owner_tag == head_tag); // codes untouched.
				end
				lc3b_types_pkg::op_trap:
				begin
					retire = 1'b1;
					wr_en = 1'b1;
					wr_clear_busy = (owner_tag == head_tag);
					flush = 1'b1;
					pc_sel = 1'b1;
				end
				lc3b_types_pkg::op_br:
				begin
					retire = 1'b1;
					flush = mispredict;
					pc_sel = mispredict;
				end
				lc3b_types_pkg::op_str:
				begin
					dmem_write = 1'b1; // held until memory acks.
					retire = dmem_resp;
				end
				default: retire = 1'b1; // drop anything unknown so the head never stalls.
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			cc <= 3'b010; // z after reset.
		else if (ld_cc)
			cc <= gen_cc;
	end

	// branch statistics.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			branch_count <= '0;
			mispredict_count <= '0;
		end
		else if (retire && head_opcode == lc3b_types_pkg::op_br)
		begin
			branch_count <= branch_count + 1'b1;
			if (mispredict)
				mispredict_count <= mispredict_count + 1'b1;
		end
	end

endmodule

//--- src/lc3b_defines.svh
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// datapath word width in bits.
`define LC3B_WORD_W 16

// architectural register count, R0 to R7.
`define LC3B_NREGS 8

// reorder buffer entries.
`define LC3B_ROB_DEPTH 8

// tag width, log2 of the ROB depth.
`define LC3B_TAG_W 3

// the ROB pointers wrap by overflow, so the depth must equal 2**tag width.
// the register index width follows from the register count.
// the condition codes are always three bits, n z p.

`endif

//--- src/lc3b_regfile.sv
`include "lc3b_defines.svh"

module lc3b_regfile
(
	input logic clk,
	input logic rst,
	input logic flush,

	input logic set_en,
	input lc3b_types_pkg::lc3b_reg set_dest,
	input lc3b_types_pkg::lc3b_rob_tag set_tag,

	input logic wr_en,
	input lc3b_types_pkg::lc3b_reg wr_dest,
	input lc3b_types_pkg::lc3b_word wr_value,
	input logic wr_clear_busy,

	output lc3b_types_pkg::lc3b_rob_tag owner_tag,

	input lc3b_types_pkg::lc3b_reg rd_sel,
	output lc3b_types_pkg::lc3b_word rd_value,
	output logic rd_busy
);

	localparam int unsigned nregs = `LC3B_NREGS;

	lc3b_types_pkg::lc3b_word regs [nregs];
	lc3b_types_pkg::lc3b_rob_tag owner [nregs]; // ROB tag of the youngest writer.
	logic [nregs-1:0] busy;

	assign owner_tag = owner[wr_dest];
	assign rd_value = regs[rd_sel];
	assign rd_busy = busy[rd_sel];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			regs[wr_dest] <= wr_value;
		if (set_en)
			owner[set_dest] <= set_tag;
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			busy <= '0; // all in-flight writers are gone.
		else
		begin
			if (wr_en && wr_clear_busy)
				busy[wr_dest] <= 1'b0;
			if (set_en)
				busy[set_dest] <= 1'b1; // new owner wins over a same-cycle clear.
		end
	end

endmodule

//--- src/lc3b_retire_top.sv
module lc3b_retire_top
(
	input logic clk,
	input logic rst,

	input logic disp_valid,
	input lc3b_types_pkg::lc3b_opcode disp_opcode,
	input lc3b_types_pkg::lc3b_reg disp_dest,
	input lc3b_types_pkg::lc3b_word disp_link,
	output logic disp_ready,
	output lc3b_types_pkg::lc3b_rob_tag disp_tag,

	input logic res_valid,
	input lc3b_types_pkg::lc3b_rob_tag res_tag,
	input lc3b_types_pkg::lc3b_word res_value,
	input logic res_predict,

	input logic dmem_resp,
	input lc3b_types_pkg::lc3b_reg rd_sel,
	output lc3b_types_pkg::lc3b_word rd_value,
	output logic rd_busy,

	output logic dmem_write,
	output logic flush,
	output logic pc_sel,
	output lc3b_types_pkg::lc3b_word new_pc,
	output logic [31:0] branch_count,
	output logic [31:0] mispredict_count
);

	logic head_valid;
	lc3b_types_pkg::lc3b_opcode head_opcode;
	lc3b_types_pkg::lc3b_reg head_dest;
	lc3b_types_pkg::lc3b_word head_value;
	logic head_predict;
	lc3b_types_pkg::lc3b_word head_link;
	lc3b_types_pkg::lc3b_rob_tag head_tag;
	logic retire;
	logic wr_en;
	lc3b_types_pkg::lc3b_reg wr_dest;
	lc3b_types_pkg::lc3b_word wr_value;
	logic wr_clear_busy;
	lc3b_types_pkg::lc3b_rob_tag owner_tag;
	logic writes_reg;
	logic set_en;

	always_comb
	begin
		case (disp_opcode)
			lc3b_types_pkg::op_add,
			lc3b_types_pkg::op_and,
			lc3b_types_pkg::op_not,
			lc3b_types_pkg::op_lea,
			lc3b_types_pkg::op_ldr,
			lc3b_types_pkg::op_jsr,
			lc3b_types_pkg::op_trap: writes_reg = 1'b1;
			default: writes_reg = 1'b0; // br and str leave registers alone.
		endcase
	end

	assign set_en = disp_valid & disp_ready & writes_reg;

	lc3b_rob rob0
	(
		.clk, .rst, .flush,
		.disp_valid, .disp_opcode, .disp_dest, .disp_link, .disp_ready, .disp_tag,
		.res_valid, .res_tag, .res_value, .res_predict,
		.head_valid, .head_opcode, .head_dest, .head_value, .head_predict,
		.head_link, .head_tag,
		.retire
	);

	lc3b_commit_control commit0
	(
		.clk, .rst,
		.head_valid, .head_opcode, .head_dest, .head_value, .head_predict,
		.head_link, .head_tag,
		.owner_tag, .dmem_resp,
		.retire, .wr_en, .wr_dest, .wr_value, .wr_clear_busy,
		.dmem_write, .flush, .pc_sel, .new_pc,
		.branch_count, .mispredict_count
	);

	lc3b_regfile regfile0
	(
		.clk, .rst, .flush,
		.set_en, .set_dest(disp_dest), .set_tag(disp_tag),
		.wr_en, .wr_dest, .wr_value, .wr_clear_busy,
		.owner_tag,
		.rd_sel, .rd_value, .rd_busy
	);

endmodule

//--- src/lc3b_rob.sv
`include "lc3b_defines.svh"

module lc3b_rob
(
	input logic clk,
	input logic rst,
	input logic flush,

	input logic disp_valid,
	input lc3b_types_pkg::lc3b_opcode disp_opcode,
	input lc3b_types_pkg::lc3b_reg disp_dest,
	input lc3b_types_pkg::lc3b_word disp_link,
	output logic disp_ready,
	output lc3b_types_pkg::lc3b_rob_tag disp_tag,

	input logic res_valid,
	input lc3b_types_pkg::lc3b_rob_tag res_tag,
	input lc3b_types_pkg::lc3b_word res_value,
	input logic res_predict,

	output logic head_valid,
	output lc3b_types_pkg::lc3b_opcode head_opcode,
	output lc3b_types_pkg::lc3b_reg head_dest,
	output lc3b_types_pkg::lc3b_word head_value,
	output logic head_predict,
	output lc3b_types_pkg::lc3b_word head_link,
	output lc3b_types_pkg::lc3b_rob_tag head_tag,

	input logic retire
);

	localparam int unsigned depth = `LC3B_ROB_DEPTH;
	localparam logic [`LC3B_TAG_W:0] full_count = (`LC3B_TAG_W + 1)'(`LC3B_ROB_DEPTH);

	lc3b_types_pkg::lc3b_opcode opcode_q [depth];
	lc3b_types_pkg::lc3b_reg dest_q [depth];
	lc3b_types_pkg::lc3b_word value_q [depth];
	lc3b_types_pkg::lc3b_word link_q [depth];
	logic predict_q [depth];
	logic [depth-1:0] done; // result present per entry.

	lc3b_types_pkg::lc3b_rob_tag head;
	lc3b_types_pkg::lc3b_rob_tag tail;
	logic [`LC3B_TAG_W:0] count; // one extra bit to tell full from empty.
	logic alloc;

	assign disp_ready = (count != full_count);
	assign disp_tag = tail;
	assign alloc = disp_valid & disp_ready;

	assign head_valid = (count != '0) & done[head];
	assign head_opcode = opcode_q[head];
	assign head_dest = dest_q[head];
	assign head_value = value_q[head];
	assign head_predict = predict_q[head];
	assign head_link = link_q[head];
	assign head_tag = head;

	// entry payload, filled at dispatch and by the result bus.
	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			opcode_q[tail] <= disp_opcode;
			dest_q[tail] <= disp_dest;
			link_q[tail] <= disp_link;
		end
		if (res_valid)
		begin
			value_q[res_tag] <= res_value;
			predict_q[res_tag] <= res_predict;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end
		else
		begin
			if (res_valid)
				done[res_tag] <= 1'b1;
			if (alloc)
			begin
				tail <= tail + 1'b1; // wraps at depth.
				done[tail] <= 1'b0; // new entry waits for its result.
			end
			if (retire)
				head <= head + 1'b1;
			case ({alloc, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither, no change.
			endcase
		end
	end

endmodule

//--- src/lc3b_types_pkg.sv
`include "lc3b_defines.svh"

package lc3b_types_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word; // data word.
	typedef logic [$clog2(`LC3B_NREGS)-1:0] lc3b_reg; // register index.
	typedef logic [`LC3B_TAG_W-1:0] lc3b_rob_tag; // ROB address.
	typedef logic [2:0] lc3b_nzp; // n, z, p.

	// LC-3b encodings, only the subset this core retires.
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage
